/* flist.f */
source/i3c_bus_pkg.sv
source/bus_monitor.sv
source/addr_capture.sv
source/addr_fifo.sv
source/addr_classify.sv
source/i3c_bus_frontend.sv
test/i3c_bus_frontend_asserts.sv
test/tb_i3c_bus_frontend.sv

/* Bender.yml */
package:
  name: i3c_bus_frontend

sources:
  - files:
      - source/i3c_bus_pkg.sv
      - source/bus_monitor.sv
      - source/addr_capture.sv
      - source/addr_fifo.sv
      - source/addr_classify.sv
      - source/i3c_bus_frontend.sv
  - target: test
    files:
      - test/i3c_bus_frontend_asserts.sv
      - test/tb_i3c_bus_frontend.sv

/* test/tb_i3c_bus_frontend.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the bus front end. Drives SCL and SDA,
// acknowledges classified addresses and checks every result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module tb_i3c_bus_frontend
  import i3c_bus_pkg::*;
();

  localparam int unsigned HalfCycles    = 8;
  localparam int unsigned TimeoutCycles = 20 * 9 * 16 + 2000;

  logic         clk = 1'b0;
  logic         rst_n;
  logic         scl;
  logic         sda;
  addr_cfg_t    addr_cfg;
  logic         bus_start;
  logic         bus_rstart;
  logic         bus_stop;
  logic         bus_scl_posedge;
  addr_result_t bus_addr;
  logic         bus_addr_valid;
  logic         bus_addr_ack;
  logic         addr_overflow;

  logic [31:0]  lcg_state;
  int unsigned  cycle_cnt = 0;
  int unsigned  start_cnt = 0;
  int unsigned  rstart_cnt = 0;
  int unsigned  stop_cnt = 0;
  int unsigned  posedge_cnt = 0;
  addr_rec_t    expected_q [$];

  i3c_bus_frontend u_i3c_bus_frontend (
    .clk_i(clk), .rst_n_i(rst_n), .scl_i(scl), .sda_i(sda), .addr_cfg_i(addr_cfg),
    .bus_start_o(bus_start), .bus_rstart_o(bus_rstart), .bus_stop_o(bus_stop),
    .bus_scl_posedge_o(bus_scl_posedge), .bus_addr_o(bus_addr),
    .bus_addr_valid_o(bus_addr_valid), .bus_addr_ack_i(bus_addr_ack),
    .addr_overflow_o(addr_overflow)
  );

  always #4 clk = ~clk;

  // Event pulse counters and watchdog
  always @(negedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (bus_start) start_cnt <= start_cnt + 1;
    if (bus_rstart) rstart_cnt <= rstart_cnt + 1;
    if (bus_stop) stop_cnt <= stop_cnt + 1;
    if (bus_scl_posedge) posedge_cnt <= posedge_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
      $display("tests failed");
      $fatal(1, "watchdog expired");
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Broadcast first, then dynamic, then static
  function automatic match_e expected_kind(input i3c_addr_t addr);
    if (addr == 7'h7E) return MATCH_BROADCAST;
    if (addr_cfg.dyn_valid && addr == addr_cfg.dyn_addr) return MATCH_DYNAMIC;
    if (addr_cfg.sta_valid && addr == addr_cfg.sta_addr) return MATCH_STATIC;
    return MATCH_NONE;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s expected %0h actual %0h", name, expected, actual);
      $display("tests failed");
      $fatal(1, "mismatch ends the run");
    end
  endtask

  task automatic check_result(input string name, input addr_rec_t exp,
                              input addr_result_t res);
    check_value({name, " addr"}, exp.addr, res.rec.addr);
    check_value({name, " rnw"}, exp.rnw, res.rec.rnw);
    check_value({name, " rstart"}, exp.rstart, res.rec.rstart);
    check_value({name, " kind"}, expected_kind(exp.addr), res.kind);
  endtask

  task automatic hold_cycles(input int unsigned n);
    repeat (n) @(negedge clk);
  endtask

  // SDA moves mid way through the SCL low phase
  task automatic send_bit(input logic b);
    scl = 1'b0;
    hold_cycles(HalfCycles / 2);
    sda = b;
    hold_cycles(HalfCycles / 2);
    scl = 1'b1;
    hold_cycles(HalfCycles);
  endtask

  task automatic send_start();
    sda = 1'b0;
    hold_cycles(HalfCycles);
  endtask

  task automatic send_rstart();
    send_bit(1'b1);
    sda = 1'b0;
    hold_cycles(HalfCycles);
  endtask

  task automatic send_stop();
    send_bit(1'b0);
    sda = 1'b1;
    hold_cycles(HalfCycles);
  endtask

  task automatic send_byte(input logic [7:0] data);
    for (int i = 7; i >= 0; i--) begin
      send_bit(data[i]);
    end
    // ACK slot
    send_bit(1'b0);
  endtask

  task automatic take_result(output addr_result_t res);
    while (!bus_addr_valid) @(negedge clk);
    res = bus_addr;
    bus_addr_ack = 1'b1;
    while (bus_addr_valid) @(negedge clk);
    bus_addr_ack = 1'b0;
    @(negedge clk);
  endtask

  task automatic test_reset();
    check_value("reset start", 0, bus_start);
    check_value("reset rstart", 0, bus_rstart);
    check_value("reset stop", 0, bus_stop);
    check_value("reset scl_posedge", 0, bus_scl_posedge);
    check_value("reset addr_valid", 0, bus_addr_valid);
    check_value("reset overflow", 0, addr_overflow);
  endtask

  task automatic test_bus_conditions();
    int unsigned  start0;
    int unsigned  rstart0;
    int unsigned  stop0;
    int unsigned  edge0;
    addr_rec_t    exp;
    addr_result_t res;
    start0  = start_cnt;
    rstart0 = rstart_cnt;
    stop0   = stop_cnt;
    edge0   = posedge_cnt;
    send_start();
    send_byte(8'hA5);
    hold_cycles(HalfCycles);
    check_value("conditions scl_posedge", 9, posedge_cnt - edge0);
    send_rstart();
    send_stop();
    hold_cycles(2 * HalfCycles);
    check_value("conditions start", 1, start_cnt - start0);
    check_value("conditions rstart", 1, rstart_cnt - rstart0);
    check_value("conditions stop", 1, stop_cnt - stop0);
    exp.addr   = 7'h52;
    exp.rnw    = 1'b1;
    exp.rstart = 1'b0;
    take_result(res);
    check_result("conditions frame", exp, res);
  endtask

  task automatic test_glitch();
    int unsigned start0;
    int unsigned stop0;
    start0 = start_cnt;
    stop0  = stop_cnt;
    sda = 1'b0;
    hold_cycles(2);
    sda = 1'b1;
    hold_cycles(2 * HalfCycles);
    check_value("glitch start", 0, start_cnt - start0);
    check_value("glitch stop", 0, stop_cnt - stop0);
  endtask

  task automatic test_classification();
    addr_rec_t    exp;
    addr_result_t res;
    logic [31:0]  rnd;
    for (int i = 0; i < 8; i++) begin
      rnd = lcg_next();
      case (i)
        5:       exp.addr = addr_cfg.sta_addr;
        6:       exp.addr = addr_cfg.dyn_addr;
        7:       exp.addr = 7'h7E;
        default: exp.addr = rnd[22:16];
      endcase
      exp.rnw    = rnd[8];
      exp.rstart = (i != 0);
      if (i == 0) send_start();
      else send_rstart();
      send_byte({exp.addr, exp.rnw});
      take_result(res);
      check_result($sformatf("classify frame %0d", i), exp, res);
    end
    send_stop();
  endtask

  task automatic test_backpressure();
    addr_rec_t    exp;
    addr_result_t res;
    logic [31:0]  rnd;
    expected_q.delete();
    for (int i = 0; i < AddrFifoDepth + 3; i++) begin
      rnd        = lcg_next();
      exp.addr   = rnd[22:16];
      exp.rnw    = rnd[9];
      exp.rstart = (i != 0);
      // Last frame finds the pipeline full and is dropped
      if (i < AddrFifoDepth + 2) expected_q.push_back(exp);
      if (i == 0) send_start();
      else send_rstart();
      send_byte({exp.addr, exp.rnw});
    end
    send_stop();
    hold_cycles(2 * HalfCycles);
    check_value("backpressure overflow", 1, addr_overflow);
    while (expected_q.size() != 0) begin
      take_result(res);
      check_result("backpressure", expected_q.pop_front(), res);
    end
    hold_cycles(4 * HalfCycles);
    check_value("backpressure extra result", 0, bus_addr_valid);
  endtask

  initial begin
    int unsigned assert_fails;
    rst_n        = 1'b0;
    scl          = 1'b1;
    sda          = 1'b1;
    bus_addr_ack = 1'b0;
    addr_cfg     = '{sta_addr: 7'h2A, sta_valid: 1'b1, dyn_addr: 7'h31, dyn_valid: 1'b1};
    lcg_state    = 32'h60a8;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_reset();
    test_bus_conditions();
    test_glitch();
    test_classification();
    test_backpressure();
    assert_fails = u_i3c_bus_frontend.u_addr_capture.u_capture_asserts.fail_cnt
                 + u_i3c_bus_frontend.u_addr_fifo.u_fifo_asserts.fail_cnt;
    if (assert_fails == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("tests failed");
      $fatal(1, "%0d assertion failures", assert_fails);
    end
  end

endmodule

/* test/i3c_bus_frontend_asserts.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent checks on a four-phase req/ack link.
// Bound into the address capture and the address FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module i3c_bus_frontend_asserts
  import i3c_bus_pkg::*;
(
  input logic      clk_i,
  input logic      rst_n_i,
  input logic      req_i,
  input logic      ack_i,
  input addr_rec_t data_i
);

  int unsigned fail_cnt = 0;

  a_req_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(req_i) |-> !ack_i)
    else begin
      $error("req rose while ack was still high");
      fail_cnt++;
    end

  a_data_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i && $past(req_i) |-> $stable(data_i))
    else begin
      $error("data changed while req was high");
      fail_cnt++;
    end

  a_req_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(req_i) |-> $past(ack_i))
    else begin
      $error("req dropped before ack was seen");
      fail_cnt++;
    end

  a_ack_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(ack_i) |-> !req_i)
    else begin
      $error("ack dropped while req was still high");
      fail_cnt++;
    end

endmodule

bind addr_capture i3c_bus_frontend_asserts u_capture_asserts (
  .clk_i, .rst_n_i, .req_i(req_o), .ack_i(ack_i), .data_i(rec_o)
);

bind addr_fifo i3c_bus_frontend_asserts u_fifo_asserts (
  .clk_i, .rst_n_i, .req_i(out_req_o), .ack_i(out_ack_i), .data_i(out_o)
);

/* source/i3c_bus_frontend.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus observation front end: monitor, address capture, address
// FIFO and classifier chained by req/ack links
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module i3c_bus_frontend
  import i3c_bus_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         scl_i,
  input  logic         sda_i,
  input  addr_cfg_t    addr_cfg_i,
  output logic         bus_start_o,
  output logic         bus_rstart_o,
  output logic         bus_stop_o,
  output logic         bus_scl_posedge_o,
  output addr_result_t bus_addr_o,
  output logic         bus_addr_valid_o,
  input  logic         bus_addr_ack_i,
  output logic         addr_overflow_o
);

  bus_event_t bus_event;
  addr_rec_t  cap_rec;
  addr_rec_t  fifo_rec;
  logic       cap_req;
  logic       cap_ack;
  logic       fifo_req;
  logic       fifo_ack;

  assign bus_start_o       = bus_event.start;
  assign bus_rstart_o      = bus_event.rstart;
  assign bus_stop_o        = bus_event.stop;
  assign bus_scl_posedge_o = bus_event.scl_posedge;

  bus_monitor u_bus_monitor (
    .clk_i, .rst_n_i, .scl_i, .sda_i, .event_o(bus_event)
  );

  addr_capture u_addr_capture (
    .clk_i, .rst_n_i, .event_i(bus_event), .rec_o(cap_rec),
    .req_o(cap_req), .ack_i(cap_ack), .overflow_o(addr_overflow_o)
  );

  addr_fifo #(.Depth(AddrFifoDepth)) u_addr_fifo (
    .clk_i, .rst_n_i, .in_i(cap_rec), .in_req_i(cap_req), .in_ack_o(cap_ack),
    .out_o(fifo_rec), .out_req_o(fifo_req), .out_ack_i(fifo_ack)
  );

  addr_classify u_addr_classify (
    .clk_i, .rst_n_i, .rec_i(fifo_rec), .req_i(fifo_req), .ack_o(fifo_ack),
    .cfg_i(addr_cfg_i), .result_o(bus_addr_o), .valid_o(bus_addr_valid_o),
    .ack_i(bus_addr_ack_i)
  );

endmodule

/* source/addr_classify.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Matches each address against the broadcast, dynamic and static
// addresses and hands the result to the recovery handler
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module addr_classify
  import i3c_bus_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  addr_rec_t    rec_i,
  input  logic         req_i,
  output logic         ack_o,
  input  addr_cfg_t    cfg_i,
  output addr_result_t result_o,
  output logic         valid_o,
  input  logic         ack_i
);

  logic   held_q;
  logic   fresh_q;
  logic   take;
  match_e kind;

  // Broadcast wins over dynamic, dynamic over static
  always_comb begin
    if (rec_i.addr == BroadcastAddr) begin
      kind = MATCH_BROADCAST;
    end else if (cfg_i.dyn_valid && rec_i.addr == cfg_i.dyn_addr) begin
      kind = MATCH_DYNAMIC;
    end else if (cfg_i.sta_valid && rec_i.addr == cfg_i.sta_addr) begin
      kind = MATCH_STATIC;
    end else begin
      kind = MATCH_NONE;
    end
  end

  assign take = req_i & ~ack_o & ~held_q;

  always_ff @(posedge clk_i) begin
    if (take) begin
      result_o <= '{rec: rec_i, kind: kind};
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      held_q  <= 1'b0;
      fresh_q <= 1'b0;
      ack_o   <= 1'b0;
      valid_o <= 1'b0;
    end else begin
      if (take) begin
        ack_o   <= 1'b1;
        held_q  <= 1'b1;
        fresh_q <= 1'b1;
      end else if (ack_o && !req_i) begin
        ack_o <= 1'b0;
      end
      // Outside handshake on the held result
      if (fresh_q && !ack_i) begin
        valid_o <= 1'b1;
        fresh_q <= 1'b0;
      end else if (valid_o && ack_i) begin
        valid_o <= 1'b0;
      end else if (held_q && !fresh_q && !valid_o && !ack_i) begin
        held_q <= 1'b0;
      end
    end
  end

endmodule

/* source/addr_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Circular buffer for address records with four-phase req/ack on
// both the write and the read side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module addr_fifo
  import i3c_bus_pkg::*;
#(
  parameter int unsigned Depth = AddrFifoDepth
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  addr_rec_t in_i,
  input  logic      in_req_i,
  output logic      in_ack_o,
  output addr_rec_t out_o,
  output logic      out_req_o,
  input  logic      out_ack_i
);

  addr_rec_t                      mem_q [Depth];
  logic [$clog2(Depth)-1:0]       wptr_q;
  logic [$clog2(Depth)-1:0]       rptr_q;
  logic [$clog2(Depth + 1)-1:0]   count_q;
  logic                           out_busy_q;
  logic                           push;
  logic                           pop;

  assign push  = in_req_i & ~in_ack_o & (count_q != Depth);
  // Head leaves once the reader has dropped its ack
  assign pop   = out_busy_q & ~out_req_o & ~out_ack_i;
  assign out_o = mem_q[rptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= in_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wptr_q     <= '0;
      rptr_q     <= '0;
      count_q    <= '0;
      in_ack_o   <= 1'b0;
      out_req_o  <= 1'b0;
      out_busy_q <= 1'b0;
    end else begin
      if (push) begin
        wptr_q   <= (wptr_q == Depth - 1) ? '0 : wptr_q + 1'b1;
        in_ack_o <= 1'b1;
      end else if (in_ack_o && !in_req_i) begin
        in_ack_o <= 1'b0;
      end
      if (pop) begin
        rptr_q     <= (rptr_q == Depth - 1) ? '0 : rptr_q + 1'b1;
        out_busy_q <= 1'b0;
      end else if (!out_busy_q && count_q != 0) begin
        out_req_o  <= 1'b1;
        out_busy_q <= 1'b1;
      end else if (out_req_o && out_ack_i) begin
        out_req_o <= 1'b0;
      end
      count_q <= count_q + push - pop;
    end
  end

endmodule

/* source/addr_capture.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shifts in the address byte after START or repeated START and offers
// it downstream over a four-phase req/ack link
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module addr_capture
  import i3c_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  bus_event_t event_i,
  output addr_rec_t  rec_o,
  output logic       req_o,
  input  logic       ack_i,
  output logic       overflow_o
);

  cap_state_e state_q;
  logic       in_byte_q;
  logic [2:0] bit_cnt_q;
  i3c_addr_t  shift_q;
  logic       rstart_q;
  logic       arm;
  logic       byte_done;
  logic       hs_done;
  logic       load;

  assign arm       = event_i.start | event_i.rstart;
  assign byte_done = in_byte_q & event_i.scl_posedge & (bit_cnt_q == 3'd7);
  assign hs_done   = (state_q == CAP_HOLD) & ~req_o & ~ack_i;
  assign load      = byte_done & ((state_q != CAP_HOLD) | hs_done);

  // Bit counter keeps running while a record is held
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_byte_q <= 1'b0;
      bit_cnt_q <= '0;
    end else if (arm) begin
      in_byte_q <= 1'b1;
      bit_cnt_q <= '0;
    end else if (event_i.stop) begin
      in_byte_q <= 1'b0;
    end else if (in_byte_q && event_i.scl_posedge) begin
      bit_cnt_q <= bit_cnt_q + 3'd1;
      if (bit_cnt_q == 3'd7) begin
        in_byte_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (arm) begin
      rstart_q <= event_i.rstart;
    end
    if (in_byte_q && event_i.scl_posedge) begin
      shift_q <= {shift_q[5:0], event_i.sda};
    end
    // Eighth bit is RnW, taken straight from the bus
    if (load) begin
      rec_o <= '{addr: shift_q, rnw: event_i.sda, rstart: rstart_q};
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= CAP_IDLE;
      req_o      <= 1'b0;
      overflow_o <= 1'b0;
    end else begin
      if (byte_done && !load) begin
        overflow_o <= 1'b1;
      end
      case (state_q)
        CAP_IDLE: begin
          if (arm) begin
            state_q <= CAP_SHIFT;
          end
        end
        CAP_SHIFT: begin
          if (load) begin
            state_q <= CAP_HOLD;
            req_o   <= 1'b1;
          end else if (event_i.stop) begin
            state_q <= CAP_IDLE;
          end
        end
        CAP_HOLD: begin
          if (req_o && ack_i) begin
            req_o <= 1'b0;
          end else if (load) begin
            req_o <= 1'b1;
          end else if (hs_done) begin
            state_q <= ((in_byte_q && !event_i.stop) || arm) ? CAP_SHIFT : CAP_IDLE;
          end
        end
        default: state_q <= CAP_IDLE;
      endcase
    end
  end

endmodule

/* source/bus_monitor.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Samples SCL and SDA, rejects short glitches and reports START,
// repeated START, STOP and SCL rising edges as registered pulses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module bus_monitor
  import i3c_bus_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       scl_i,
  input  logic       sda_i,
  output bus_event_t event_o
);

  // Bit 1 carries SCL, bit 0 carries SDA
  logic [1:0] sync_q1;
  logic [1:0] sync_q2;
  logic [1:0] filt_q;
  logic [1:0] filt_prev_q;
  filt_cnt_t  cnt_q [2];
  logic       busy_q;
  logic       scl_high;
  logic       scl_rise;
  logic       sda_fall;
  logic       sda_rise;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q1     <= 2'b11;
      sync_q2     <= 2'b11;
      filt_q      <= 2'b11;
      filt_prev_q <= 2'b11;
      for (int i = 0; i < 2; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      sync_q1     <= {scl_i, sda_i};
      sync_q2     <= sync_q1;
      filt_prev_q <= filt_q;
      for (int i = 0; i < 2; i++) begin
        if (sync_q2[i] == filt_q[i]) begin
          cnt_q[i] <= '0;
        end else if (cnt_q[i] == filt_cnt_t'(FilterCycles - 1)) begin
          filt_q[i] <= sync_q2[i];
          cnt_q[i]  <= '0;
        end else begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign scl_high = filt_q[1] & filt_prev_q[1];
  assign scl_rise = filt_q[1] & ~filt_prev_q[1];
  assign sda_fall = filt_prev_q[0] & ~filt_q[0];
  assign sda_rise = ~filt_prev_q[0] & filt_q[0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q      <= 1'b0;
      event_o     <= '0;
      event_o.sda <= 1'b1;
    end else begin
      event_o.start       <= sda_fall & scl_high & ~busy_q;
      event_o.rstart      <= sda_fall & scl_high & busy_q;
      event_o.stop        <= sda_rise & scl_high;
      event_o.scl_posedge <= scl_rise;
      event_o.sda         <= filt_q[0];
      // Bus stays busy from START until STOP
      if (sda_rise && scl_high) begin
        busy_q <= 1'b0;
      end else if (sda_fall && scl_high) begin
        busy_q <= 1'b1;
      end
    end
  end

endmodule

/* source/i3c_bus_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, constants and record types for the I3C bus
// observation path. Imported by every RTL module and the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package i3c_bus_pkg;

  // Consecutive equal samples before a filtered line may change
  localparam int unsigned FilterCycles = 4;
  localparam int unsigned AddrFifoDepth = 4;

  typedef logic [6:0] i3c_addr_t;
  typedef logic [$clog2(FilterCycles + 1)-1:0] filt_cnt_t;

  localparam i3c_addr_t BroadcastAddr = 7'h7E;

  // One-cycle pulses plus the filtered SDA level
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
    logic scl_posedge;
    logic sda;
  } bus_event_t;

  typedef struct packed {
    i3c_addr_t addr;
    logic      rnw;
    logic      rstart;
  } addr_rec_t;

  typedef struct packed {
    i3c_addr_t sta_addr;
    logic      sta_valid;
    i3c_addr_t dyn_addr;
    logic      dyn_valid;
  } addr_cfg_t;

  typedef enum logic [1:0] {
    MATCH_NONE,
    MATCH_STATIC,
    MATCH_DYNAMIC,
    MATCH_BROADCAST
  } match_e;

  typedef struct packed {
    addr_rec_t rec;
    match_e    kind;
  } addr_result_t;

  typedef enum logic [1:0] {
    CAP_IDLE,
    CAP_SHIFT,
    CAP_HOLD
  } cap_state_e;

endpackage
